/* design/cordic_pkg.sv */
// cordic constants
// stage count, datapath widths, arctangent table and gain of the rotator

package cordic_pkg;

  // ====================================================================
  // pipeline geometry
  // ====================================================================

  localparam int n_stages   = 14;  // shift-add rotation stages
  localparam int work_width = 20;  // signed x/y width inside the rotator
  localparam int angle_width = 20; // residual phase width, full turn = 2^20

  // pre-rotation + stages + rounding
  localparam int rot_latency = n_stages + 2;

  // uncompensated gain, product of sqrt(1 + 2^-2i) over all stages
  // 1.646760 in thousandths, the rotator output carries it
  localparam int cordic_gain_milli = 1647;

  // ====================================================================
  // arctangent table
  // ====================================================================

  // atan(2^-i) as a fraction of a full turn, scaled by 2^20
  localparam logic [angle_width-1:0] angle_table [n_stages] = '{
    20'd131072, // 45.000000 deg
    20'd77376,  // 26.565051 deg
    20'd40884,  // 14.036243 deg
    20'd20753,  //  7.125016 deg
    20'd10417,  //  3.576334 deg
    20'd5213,   //  1.789911 deg
    20'd2607,   //  0.895174 deg
    20'd1304,   //  0.447614 deg
    20'd652,    //  0.223811 deg
    20'd326,    //  0.111906 deg
    20'd163,    //  0.055953 deg
    20'd81,     //  0.027976 deg
    20'd41,     //  0.013988 deg
    20'd20      //  0.006994 deg
  };

  // residual after the last stage is within about one table entry
  // of zero, i.e. roughly 20 / 2^20 of a turn

  // the table starts at atan(1), so together with the octant
  // pre-rotation any residual within +-45 deg converges

  // x/y headroom: |amp| * K < 2 * 2^(amp_width-1), kept by two
  // integer guard bits above the amplitude in the working word

  // fractional guard bits are the remainder of work_width below iq_width,
  // they absorb the truncation of the arithmetic shifts

endpackage

/* design/dds_pkg.sv */
// tone-level types
// phase word, amplitude, per-tone config and the I/Q sample structs

package dds_pkg;

  // ====================================================================
  // widths
  // ====================================================================

  localparam int phase_width = 20; // full turn = 2^20, top 3 bits = octant
  localparam int amp_width   = 12; // signed amplitude
  localparam int iq_width    = 14; // rotator result, carries the cordic gain
  localparam int out_width   = 13; // mixer output after saturation

  // ====================================================================
  // types
  // ====================================================================

  typedef logic [phase_width-1:0] phase_t;

  // settings of one tone
  typedef struct packed {
    phase_t                        tuning;    // phase step per sample
    logic signed [amp_width-1:0]   amplitude;
  } tone_cfg_t;

  // settings of both tones, loaded together
  typedef struct packed {
    tone_cfg_t tone_a;
    tone_cfg_t tone_b;
  } tone_cfg_pair_t;

  // one rotator result
  typedef struct packed {
    logic signed [iq_width-1:0] i_val;
    logic signed [iq_width-1:0] q_val;
  } iq_t;

  // final mixed sample
  typedef struct packed {
    logic signed [out_width-1:0] i_val;
    logic signed [out_width-1:0] q_val;
  } mix_t;

endpackage

/* design/cordic_rotator.sv */
// pipelined cordic rotator
// octant pre-rotation, shift-add stages and round-to-even of x/y

`timescale 1ns/100ps

module cordic_rotator (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_strobe,
  input  logic signed [dds_pkg::amp_width-1:0] i_amp,
  input  dds_pkg::phase_t                     i_phase,
  output logic                                o_strobe,
  output dds_pkg::iq_t                        o_iq
);

  // fraction bits below the output lsb
  localparam int frac_bits = cordic_pkg::work_width - dds_pkg::iq_width;
  localparam int ext_bits  = dds_pkg::iq_width - dds_pkg::amp_width;
  localparam int pw        = dds_pkg::phase_width;

  logic signed [cordic_pkg::work_width-1:0] e_amp;
  logic signed [cordic_pkg::work_width-1:0] xv [0:cordic_pkg::n_stages];
  logic signed [cordic_pkg::work_width-1:0] yv [0:cordic_pkg::n_stages];
  dds_pkg::phase_t                          ph [0:cordic_pkg::n_stages-1];
  logic [cordic_pkg::rot_latency-1:0]       stb_sr;

  // amplitude on the x axis with headroom for the gain
  assign e_amp = {{ext_bits{i_amp[dds_pkg::amp_width-1]}}, i_amp, {frac_bits{1'b0}}};

  // round to nearest with ties to even, dropping frac_bits
  function automatic logic signed [dds_pkg::iq_width-1:0] round_even(
    input logic signed [cordic_pkg::work_width-1:0] v
  );
    logic [cordic_pkg::work_width-1:0] bias;
    logic [cordic_pkg::work_width-1:0] sum;
    bias                  = '0;
    bias[frac_bits-1]     = v[frac_bits];                 // half when kept lsb is odd
    bias[frac_bits-2:0]   = {(frac_bits-1){~v[frac_bits]}}; // else half minus one
    sum                   = v + bias;
    return sum[cordic_pkg::work_width-1:frac_bits];
  endfunction

  // ====================================================================
  // pre-rotation and shift-add stages
  // ====================================================================

  always_ff @(posedge i_clk) begin
    // quarter-turn rotation leaves the residual within +-45 deg
    case (i_phase[pw-1 -: 3])
      3'b000, 3'b111: begin
        xv[0] <= e_amp;
        yv[0] <= '0;
        ph[0] <= i_phase;
      end
      3'b001, 3'b010: begin // around 90 deg
        xv[0] <= '0;
        yv[0] <= e_amp;
        ph[0] <= i_phase - {2'd1, {(pw-2){1'b0}}};
      end
      3'b011, 3'b100: begin // around 180 deg
        xv[0] <= -e_amp;
        yv[0] <= '0;
        ph[0] <= i_phase - {2'd2, {(pw-2){1'b0}}};
      end
      default: begin // around 270 deg
        xv[0] <= '0;
        yv[0] <= -e_amp;
        ph[0] <= i_phase - {2'd3, {(pw-2){1'b0}}};
      end
    endcase

    for (int s = 0; s < cordic_pkg::n_stages; s++) begin
      if (ph[s][pw-1]) begin
        // negative residual rotates clockwise
        xv[s+1] <= xv[s] + (yv[s] >>> s);
        yv[s+1] <= yv[s] - (xv[s] >>> s);
      end else begin
        xv[s+1] <= xv[s] - (yv[s] >>> s);
        yv[s+1] <= yv[s] + (xv[s] >>> s);
      end
    end

    // no residual is kept after the last stage
    for (int s = 0; s < cordic_pkg::n_stages - 1; s++) begin
      if (ph[s][pw-1]) begin
        ph[s+1] <= ph[s] + cordic_pkg::angle_table[s];
      end else begin
        ph[s+1] <= ph[s] - cordic_pkg::angle_table[s];
      end
    end
  end

  // ====================================================================
  // output rounding and strobe
  // ====================================================================

  always_ff @(posedge i_clk) begin
    o_iq.i_val <= round_even(xv[cordic_pkg::n_stages]); // cos
    o_iq.q_val <= round_even(yv[cordic_pkg::n_stages]); // sin
  end

  // strobe follows the data through every register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stb_sr <= '0;
    end else begin
      stb_sr <= {stb_sr[cordic_pkg::rot_latency-2:0], i_strobe};
    end
  end

  assign o_strobe = stb_sr[cordic_pkg::rot_latency-1];

endmodule

/* design/tone_channel.sv */
// one tone channel
// phase accumulator feeding a cordic rotator, one I/Q result per sample strobe

`timescale 1ns/100ps

module tone_channel (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_cfg_strobe,
  input  logic               i_sample_strobe,
  input  dds_pkg::tone_cfg_t i_cfg,
  output logic               o_iq_strobe,
  output dds_pkg::iq_t       o_iq
);

  dds_pkg::tone_cfg_t                  cfg_q;     // registered settings
  dds_pkg::phase_t                     acc_q;     // phase of the next sample
  dds_pkg::phase_t                     rot_phase;
  logic signed [dds_pkg::amp_width-1:0] rot_amp;

  // ====================================================================
  // settings and phase accumulator
  // ====================================================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cfg_q <= '0;
      acc_q <= '0;
    end else if (i_cfg_strobe) begin
      cfg_q <= i_cfg;
      // a sample in the same cycle already used phase zero
      acc_q <= i_sample_strobe ? i_cfg.tuning : '0;
    end else if (i_sample_strobe) begin
      acc_q <= acc_q + cfg_q.tuning; // wraps modulo a full turn
    end
  end

  // config wins over the sample in the same cycle
  always_comb begin
    if (i_cfg_strobe) begin
      rot_phase = '0;
      rot_amp   = i_cfg.amplitude;
    end else begin
      rot_phase = acc_q;
      rot_amp   = cfg_q.amplitude;
    end
  end

  // ====================================================================
  // rotator
  // ====================================================================

  cordic_rotator cordic_rotator_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_strobe (i_sample_strobe),
    .i_amp    (rot_amp),
    .i_phase  (rot_phase),
    .o_strobe (o_iq_strobe),
    .o_iq     (o_iq)
  );

endmodule

/* design/tone_mixer.sv */
// tone mixer
// adds two I/Q results, saturates to the output width and registers the sample

`timescale 1ns/100ps

module tone_mixer (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_strobe,
  input  dds_pkg::iq_t i_iq_a,
  input  dds_pkg::iq_t i_iq_b,
  output logic         o_sample_strobe,
  output dds_pkg::mix_t o_sample
);

  // limits of the output range
  localparam logic signed [dds_pkg::iq_width:0] sat_max = (2 ** (dds_pkg::out_width - 1)) - 1;
  localparam logic signed [dds_pkg::iq_width:0] sat_min = -(2 ** (dds_pkg::out_width - 1));

  logic signed [dds_pkg::iq_width:0] sum_i; // one bit wider than the inputs
  logic signed [dds_pkg::iq_width:0] sum_q;

  function automatic logic signed [dds_pkg::out_width-1:0] clamp(
    input logic signed [dds_pkg::iq_width:0] v
  );
    logic signed [dds_pkg::iq_width:0] lim;
    if (v > sat_max) begin
      lim = sat_max;
    end else if (v < sat_min) begin
      lim = sat_min;
    end else begin
      lim = v;
    end
    return lim[dds_pkg::out_width-1:0];
  endfunction

  always_comb begin
    sum_i = i_iq_a.i_val + i_iq_b.i_val;
    sum_q = i_iq_a.q_val + i_iq_b.q_val;
  end

  // ====================================================================
  // output register
  // ====================================================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_sample_strobe <= 1'b0;
      o_sample        <= '0;
    end else begin
      o_sample_strobe <= i_strobe;
      if (i_strobe) begin
        o_sample.i_val <= clamp(sum_i);
        o_sample.q_val <= clamp(sum_q);
      end
    end
  end

endmodule

/* design/dual_tone_top.sv */
// dual-tone quadrature generator
// two tone channels side by side, summed and saturated by the mixer

`timescale 1ns/100ps

module dual_tone_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_cfg_strobe,
  input  logic                    i_sample_strobe,
  input  dds_pkg::tone_cfg_pair_t i_cfg,
  output logic                    o_sample_strobe,
  output dds_pkg::mix_t           o_sample
);

  logic         iq_strobe;  // channel a only, b runs in lockstep
  dds_pkg::iq_t iq_a;
  dds_pkg::iq_t iq_b;

  tone_channel tone_channel_a_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cfg_strobe    (i_cfg_strobe),
    .i_sample_strobe (i_sample_strobe),
    .i_cfg           (i_cfg.tone_a),
    .o_iq_strobe     (iq_strobe),
    .o_iq            (iq_a)
  );

  tone_channel tone_channel_b_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cfg_strobe    (i_cfg_strobe),
    .i_sample_strobe (i_sample_strobe),
    .i_cfg           (i_cfg.tone_b),
    .o_iq_strobe     (),
    .o_iq            (iq_b)
  );

  tone_mixer tone_mixer_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_strobe        (iq_strobe),
    .i_iq_a          (iq_a),
    .i_iq_b          (iq_b),
    .o_sample_strobe (o_sample_strobe),
    .o_sample        (o_sample)
  );

endmodule

/* testbench/dual_tone_assert.sv */
// strobe timing checks for the dual-tone generator
// bound to the top level to watch the sample strobes at its ports

`timescale 1ns/100ps

module dual_tone_assert (
  input logic i_clk,
  input logic i_rst,
  input logic i_sample_strobe,
  input logic o_sample_strobe
);

  localparam int latency = 17; // rotator plus mixer register

  int fail_count = 0; // number of failed checks

  // quiet while reset acts and in the cycle after
  reset_quiet: assert property (
    @(posedge i_clk) ($past(i_rst) || $past(i_rst, 2)) |-> !o_sample_strobe
  ) else begin
    fail_count++;
    $error("output strobe high during or right after reset");
  end

  strobe_followed: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $past(i_sample_strobe, latency) |-> o_sample_strobe
  ) else begin
    fail_count++;
    $error("sample strobe not answered by an output strobe");
  end

  // no output without a sample strobe at the right distance
  strobe_has_source: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_sample_strobe |-> $past(i_sample_strobe, latency)
  ) else begin
    fail_count++;
    $error("output strobe without a matching sample strobe");
  end

endmodule

bind dual_tone_top dual_tone_assert dual_tone_assert_i (
  .i_clk           (i_clk),
  .i_rst           (i_rst),
  .i_sample_strobe (i_sample_strobe),
  .o_sample_strobe (o_sample_strobe)
);

/* testbench/dual_tone_tb.sv */
// testbench for the dual-tone quadrature generator
// directed tests against a real-valued model of the two summed tones

`timescale 1ns/100ps

module dual_tone_tb;

  localparam int  clk_period = 20;
  localparam int  latency    = 17;        // sample strobe to output strobe
  localparam int  tol        = 4;         // lsb per result
  localparam real k_gain     = 1.646760;  // uncompensated cordic gain
  localparam real two_pi     = 6.283185307179586;
  localparam real full_turn  = 1048576.0; // 2^20
  localparam int  out_max    = 2 ** (dds_pkg::out_width - 1) - 1;
  localparam int  n_walk     = 16;
  localparam int  n_burst    = 40;
  localparam int  n_sat      = 24;
  localparam int  n_reconf   = 6;
  // test lengths plus one drain per test and a margin
  localparam int  watchdog_cycles = 2 + 24 + 3 * latency + 3 * n_walk + n_burst + n_sat
                                    + 3 * n_reconf + 12 * latency + 200;

  logic                    i_clk;
  logic                    i_rst;
  logic                    i_cfg_strobe;
  logic                    i_sample_strobe;
  dds_pkg::tone_cfg_pair_t i_cfg;
  logic                    o_sample_strobe;
  dds_pkg::mix_t           o_sample;

  dds_pkg::tone_cfg_pair_t model_cfg;  // settings loaded into the DUT
  dds_pkg::phase_t         model_ph_a;
  dds_pkg::phase_t         model_ph_b;
  dds_pkg::mix_t           exp_q [$];  // issue order
  dds_pkg::mix_t           got_q [$];  // arrival order
  int                      seed = 21834;
  int                      test_errors;
  int                      total_errors;
  int                      tests_run;

  dual_tone_top dual_tone_top_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cfg_strobe    (i_cfg_strobe),
    .i_sample_strobe (i_sample_strobe),
    .i_cfg           (i_cfg),
    .o_sample_strobe (o_sample_strobe),
    .o_sample        (o_sample)
  );

  initial i_clk = 1'b0;
  always #(clk_period / 2) i_clk = ~i_clk;

  always @(negedge i_clk) begin
    if (o_sample_strobe) begin
      got_q.push_back(o_sample);
    end
  end

  // ====================================================================
  // model
  // ====================================================================

  function automatic logic signed [dds_pkg::out_width-1:0] clamp_out(input real v);
    int r;
    if (v > real'(out_max)) begin
      r = out_max;
    end else if (v < -real'(out_max) - 1.0) begin
      r = -out_max - 1;
    end else begin
      r = int'(v); // nearest
    end
    return r[dds_pkg::out_width-1:0];
  endfunction

  function automatic dds_pkg::mix_t ideal_mix(input dds_pkg::tone_cfg_pair_t c,
                                              input dds_pkg::phase_t pa,
                                              input dds_pkg::phase_t pb);
    real ang_a;
    real ang_b;
    real amp_a;
    real amp_b;
    dds_pkg::mix_t m;
    ang_a   = two_pi * real'(pa) / full_turn;
    ang_b   = two_pi * real'(pb) / full_turn;
    amp_a   = k_gain * real'($signed(c.tone_a.amplitude));
    amp_b   = k_gain * real'($signed(c.tone_b.amplitude));
    m.i_val = clamp_out(amp_a * $cos(ang_a) + amp_b * $cos(ang_b));
    m.q_val = clamp_out(amp_a * $sin(ang_a) + amp_b * $sin(ang_b));
    return m;
  endfunction

  // one cycle of stimulus where a config applies before a sample in the same cycle
  task automatic step(input logic cfg_en, input dds_pkg::tone_cfg_pair_t cfg,
                      input logic smp_en);
    @(negedge i_clk);
    i_cfg_strobe    = cfg_en;
    i_sample_strobe = smp_en;
    if (cfg_en) begin
      i_cfg      = cfg;
      model_cfg  = cfg;
      model_ph_a = '0;
      model_ph_b = '0;
    end
    if (smp_en) begin
      exp_q.push_back(ideal_mix(model_cfg, model_ph_a, model_ph_b));
      model_ph_a = model_ph_a + model_cfg.tone_a.tuning; // wraps at a full turn
      model_ph_b = model_ph_b + model_cfg.tone_b.tuning;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, model_cfg, 1'b0);
  endtask

  // ====================================================================
  // checks
  // ====================================================================

  task automatic compare_sample(input dds_pkg::mix_t exp_s, input dds_pkg::mix_t act_s,
                                input string name);
    int di;
    int dq;
    di = int'(exp_s.i_val) - int'(act_s.i_val);
    dq = int'(exp_s.q_val) - int'(act_s.q_val);
    if (di > tol || di < -tol || dq > tol || dq < -tol) begin
      $display("error %s: expected i=%0d q=%0d, actual i=%0d q=%0d", name,
               exp_s.i_val, exp_s.q_val, act_s.i_val, act_s.q_val);
      test_errors++;
    end
  endtask

  task automatic compare_strobe_latency(input int exp_c, input int act_c, input string name);
    if (exp_c != act_c) begin
      $display("error %s: expected latency %0d cycles, actual %0d", name, exp_c, act_c);
      test_errors++;
    end
  endtask

  // wait for every issued sample, then compare in order
  task automatic drain_check(input string name);
    int waited;
    idle(1);
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < 2 * latency) begin
      @(posedge i_clk);
      waited++;
    end
    repeat (2) @(posedge i_clk); // room for a stray extra strobe
    if (got_q.size() != exp_q.size()) begin
      $display("error %s: expected %0d output samples, actual %0d", name,
               exp_q.size(), got_q.size());
      test_errors++;
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      compare_sample(exp_q.pop_front(), got_q.pop_front(), name);
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    $display("test %s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  // ====================================================================
  // tests
  // ====================================================================

  task automatic test_reset_state();
    repeat (24) begin
      idle(1);
      if (o_sample_strobe !== 1'b0) begin
        $display("error reset_state: output strobe went high with no sample strobe");
        test_errors++;
      end
      compare_sample('0, o_sample, "reset_state");
    end
    step(1'b0, model_cfg, 1'b1); // zero configs give silent tones
    drain_check("reset_state");
    finish_test("reset_state");
  endtask

  task automatic test_latency();
    int cycles;
    step(1'b0, model_cfg, 1'b1);
    cycles = 0;
    do begin
      idle(1);
      cycles++;
    end while (!o_sample_strobe && cycles < 3 * latency);
    compare_strobe_latency(latency, cycles, "latency");
    drain_check("latency");
    finish_test("latency");
  endtask

  task automatic test_octant_walk();
    dds_pkg::tone_cfg_pair_t c;
    c                  = '0;
    c.tone_a.tuning    = dds_pkg::phase_t'((1 << 17) + 1237); // just over one octant
    c.tone_a.amplitude = 12'sd1500;
    c.tone_b.tuning    = dds_pkg::phase_t'(5000);             // silent tone b
    step(1'b1, c, 1'b0);
    repeat (3) step(1'b0, c, 1'b1); // leave the accumulator off zero
    step(1'b1, c, 1'b0);            // reload clears the phase
    repeat (n_walk) begin
      step(1'b0, c, 1'b1);
      idle(2);
    end
    drain_check("octant_walk");
    finish_test("octant_walk");
  endtask

  task automatic test_two_tone_burst();
    dds_pkg::tone_cfg_pair_t c;
    c.tone_a.tuning    = dds_pkg::phase_t'($random(seed));
    c.tone_b.tuning    = dds_pkg::phase_t'($random(seed));
    c.tone_a.amplitude = 12'($random(seed) % 1200); // sum stays below 4096 / K
    c.tone_b.amplitude = 12'($random(seed) % 1200);
    step(1'b1, c, 1'b0);
    repeat (n_burst) step(1'b0, c, 1'b1);
    drain_check("two_tone_burst");
    finish_test("two_tone_burst");
  endtask

  task automatic test_saturation();
    dds_pkg::tone_cfg_pair_t c;
    c.tone_a.tuning    = 20'd43690; // about 15 deg per sample
    c.tone_b.tuning    = 20'd43690;
    c.tone_a.amplitude = 12'sd2047;
    c.tone_b.amplitude = 12'sd2047;
    step(1'b1, c, 1'b0);
    repeat (n_sat) step(1'b0, c, 1'b1);
    drain_check("saturation");
    finish_test("saturation");
  endtask

  task automatic test_reconfig();
    dds_pkg::tone_cfg_pair_t c1;
    dds_pkg::tone_cfg_pair_t c2;
    c1 = {20'd70001, 12'sd900, 20'd190003, -12'sd700};
    c2 = {20'd65537, -12'sd1000, 20'd300007, 12'sd1100};
    step(1'b1, c1, 1'b0);
    repeat (n_reconf) step(1'b0, c1, 1'b1);
    step(1'b1, c2, 1'b0);               // old samples still in flight
    repeat (n_reconf) step(1'b0, c2, 1'b1);
    step(1'b1, c1, 1'b1);               // sample in the same cycle sees phase zero
    repeat (3) step(1'b0, c1, 1'b1);
    drain_check("reconfig");
    finish_test("reconfig");
  endtask

  // ====================================================================
  // run
  // ====================================================================

  initial begin
    i_rst           = 1'b1;
    i_cfg_strobe    = 1'b0;
    i_sample_strobe = 1'b0;
    i_cfg           = '0;
    model_cfg       = '0;
    model_ph_a      = '0;
    model_ph_b      = '0;
    test_errors     = 0;
    total_errors    = 0;
    tests_run       = 0;
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    test_reset_state();
    test_latency();
    test_octant_walk();
    test_two_tone_burst();
    test_saturation();
    test_reconfig();
    if (dual_tone_top_i.dual_tone_assert_i.fail_count != 0) begin
      $display("strobe timing assertions failed %0d times",
               dual_tone_top_i.dual_tone_assert_i.fail_count);
      total_errors += dual_tone_top_i.dual_tone_assert_i.fail_count;
    end
    $display("summary: %0d tests run, %0d errors", tests_run, total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sources.f */
design/cordic_pkg.sv
design/dds_pkg.sv
design/cordic_rotator.sv
design/tone_channel.sv
design/tone_mixer.sv
design/dual_tone_top.sv
testbench/dual_tone_assert.sv
testbench/dual_tone_tb.sv

/* Makefile */
# Verilator build and run of the dual-tone generator testbench

TOOL     = verilator
TOP      = dual_tone_tb
FILELIST = sources.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the testbench, log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
